// ==== compile.f ====
rtl/ctrlPkg.sv
rtl/mainDecoder.sv
rtl/excUnit.sv
rtl/ctrlUnit.sv
verif/tbClock.sv
verif/tbCtrlUnit.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tbCtrlUnit -f compile.f -o VtbCtrlUnit
status=0
./obj_dir/VtbCtrlUnit > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "Done: errors found" sim.log; then
	echo "simulation failed"
	exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Done: no errors" sim.log; then
	echo "simulation ended abnormally"
	exit 1
fi
echo "simulation passed"

// ==== verif/tbCtrlUnit.sv ====
`timescale 1ns/1ps

module tbCtrlUnit import ctrlPkg::*; ();

	localparam int NumInts = 8;
	localparam int ClkPeriod = 8;
	localparam int NumTests = 6;
	localparam int CyclesPerTest = 64;
	localparam int Margin = 100;

	localparam logic [5:0] KeptOpc [20] = '{OpcLb, OpcLh, OpcLw, OpcLbu, OpcLhu, OpcSb, OpcSh,
		OpcSw, OpcBeq, OpcBne, OpcJ, OpcJal, OpcAddi, OpcAddiu, OpcSlti, OpcSltiu, OpcAndi,
		OpcOri, OpcXori, OpcLui};
	localparam logic [5:0] KeptFun [26] = '{FunSll, FunSrl, FunSra, FunSllv, FunSrlv, FunSrav,
		FunJr, FunSyscall, FunMfhi, FunMthi, FunMflo, FunMtlo, FunMult, FunMultu, FunDiv,
		FunDivu, FunAdd, FunAddu, FunSub, FunSubu, FunAnd, FunOr, FunXor, FunNor, FunSlt,
		FunSltu};
	// blez, opcode 3f, funct 01, bltz, mfc1, bc1, lwc1, swc1, cop0 fmt 2, tlbr
	localparam logic [31:0] BadWords [10] = '{32'h18000010, 32'hfc000123, 32'h00851801,
		32'h04800010, 32'h44041000, 32'h45010004, 32'hc4820008, 32'he4820008,
		32'h40400000, 32'h42000001};

	logic               clk;
	logic               rstN;
	instrWord_u         instr;
	logic               excLevel;
	logic               userMode;
	logic               aluOverflow;
	logic [NumInts-1:0] pendingInt;
	ctrlWord_t          ctrl;
	cop0Ctrl_t          cop0;

	// expected result of the instruction issued one edge earlier
	ctrlWord_t   expCtrl;
	cop0Ctrl_t   expCop0;
	string       expName;
	logic        havePrev = 1'b0;
	logic [31:0] lfsr = 32'h9be028ca;

	tbClock #(.HalfPeriod(ClkPeriod / 2)) i_tbClock (.clk(clk));

	ctrlUnit #(
		.NumInts (NumInts)
	) i_ctrlUnit (
		.iCLK        (clk),
		.rstN        (rstN),
		.instr       (instr),
		.excLevel    (excLevel),
		.userMode    (userMode),
		.aluOverflow (aluOverflow),
		.pendingInt  (pendingInt),
		.ctrl        (ctrl),
		.cop0        (cop0)
	);

	function automatic logic lfsrStep();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'hd0000001;
		return b;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[30:0], lfsrStep()};
		return r;
	endfunction

	function automatic instrWord_u mkWord(input logic [5:0] opc, input logic [4:0] rs,
		input logic [4:0] rt, input logic [5:0] fn);
		return {opc, rs, rt, 5'd9, 5'd2, fn};
	endfunction

	task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			$display("ERR %0t %s: got %0h, expected %0h", $time, what, got, exp);
			$display("Done: errors found");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic refModel(input instrWord_u w, input logic xl, input logic um, input logic ov,
		input logic [NumInts-1:0] pi, output ctrlWord_t c, output cop0Ctrl_t e);
		excClass_e cls;
		logic bd;
		logic wantW;
		logic wantE;
		logic irq;
		c = '0;
		e = '0;
		cls = ClsNone;
		bd = 1'b0;
		wantW = 1'b0;
		wantE = 1'b0;
		irq = |pi;
		case (w.r.opcode)
			OpcLb, OpcLh, OpcLw, OpcLbu, OpcLhu:
				c = '{RdRt, SrcSignImm, AluAdd, WbMem, PcNext, 1'b1, 1'b1, 1'b0};
			OpcSb, OpcSh, OpcSw:
				c = '{RdRt, SrcSignImm, AluAdd, WbAlu, PcNext, 1'b0, 1'b0, 1'b1};
			OpcBeq, OpcBne:
			begin
				c = '{RdRt, SrcReg, AluSub, WbAlu, PcBeq, 1'b0, 1'b0, 1'b0};
				if (w.r.opcode == OpcBne)
					c.pcSrc = PcBne;
				bd = 1'b1;
			end
			OpcJ:
			begin
				c = '{RdRd, SrcReg, AluAdd, WbAlu, PcJump, 1'b0, 1'b0, 1'b0};
				bd = 1'b1;
			end
			OpcJal:
			begin
				c = '{RdRa, SrcReg, AluAdd, WbPc4, PcJump, 1'b1, 1'b0, 1'b0};
				bd = 1'b1;
			end
			OpcAddi, OpcAddiu, OpcSlti, OpcSltiu:
			begin
				c = '{RdRt, SrcSignImm, AluImm, WbAlu, PcNext, 1'b1, 1'b0, 1'b0};
				cls = (w.r.opcode == OpcAddi) ? ClsAluOvf : ClsNone;
			end
			OpcAndi, OpcOri, OpcXori:
				c = '{RdRt, SrcZeroImm, AluImm, WbAlu, PcNext, 1'b1, 1'b0, 1'b0};
			OpcLui:
				c = '{RdRt, SrcReg, AluAdd, WbLui, PcNext, 1'b1, 1'b0, 1'b0};
			OpcBgeLtz:
				if (w.r.rt == RtBgez)
				begin
					c = '{RdRt, SrcZero, AluImm, WbAlu, PcBeq, 1'b0, 1'b0, 1'b0};
					bd = 1'b1;
				end
				else
					cls = ClsReserved;
			OpcRfmt:
				case (w.r.funct)
					FunJr:
					begin
						c.pcSrc = PcJr;
						bd = 1'b1;
					end
					FunSyscall:
					begin
						c.pcSrc = PcExc;
						cls = ClsSyscall;
					end
					FunSll, FunSrl, FunSra, FunSllv, FunSrlv, FunSrav, FunMfhi, FunMthi, FunMflo,
					FunMtlo, FunMult, FunMultu, FunDiv, FunDivu, FunAdd, FunAddu, FunSub, FunSubu,
					FunAnd, FunOr, FunXor, FunNor, FunSlt, FunSltu:
					begin
						c = '{RdRd, SrcReg, AluFunct, WbAlu, PcNext, 1'b1, 1'b0, 1'b0};
						if (w.r.funct == FunAdd || w.r.funct == FunSub)
							cls = ClsAluOvf;
					end
					default: cls = ClsReserved;
				endcase
			OpcCop0:
				if (w.c.fmt == FmtMf)
				begin
					c = '{RdRt, SrcReg, AluAdd, WbCop0, PcNext, 1'b1, 1'b0, 1'b0};
					cls = ClsPriv;
				end
				else if (w.c.fmt == FmtMt)
				begin
					cls = ClsPriv;
					wantW = 1'b1;
				end
				else if (w.c.fmt == FmtEret && w.c.funct == FunEret)
				begin
					c.pcSrc = PcExc;
					cls = ClsPriv;
					wantE = 1'b1;
				end
				else
					cls = ClsReserved;
			default: cls = ClsReserved;
		endcase

		e.branchDelay = bd;
		case (cls)
			ClsNone: e.excOccurred = irq && !xl;
			ClsAluOvf:
			begin
				e.excOccurred = (ov || irq) && !xl;
				e.excCode = ov ? ExcOv : ExcInt;
			end
			ClsSyscall:
			begin
				e.excOccurred = !xl;
				e.excCode = ExcSys;
			end
			ClsReserved:
			begin
				e.excOccurred = !xl;
				e.excCode = ExcRi;
			end
			ClsPriv:
			begin
				e.excOccurred = um; // user mode may not touch COP0
				e.excCode = ExcRi;
				e.regWrite = wantW && !um;
				e.eret = wantE && !um;
			end
			default: ;
		endcase
	endtask

	task automatic compareOutputs();
		if (havePrev)
		begin
			checkEq(32'(ctrl), 32'(expCtrl), {expName, " ctrl"});
			checkEq(32'(cop0), 32'(expCop0), {expName, " cop0"});
		end
	endtask

	// issue one instruction per edge and check the previous one in mid cycle
	task automatic step(input instrWord_u w, input logic xl, input logic um, input logic ov,
		input logic [NumInts-1:0] pi, input string name);
		ctrlWord_t c;
		cop0Ctrl_t e;
		@(posedge clk);
		instr <= w;
		excLevel <= xl;
		userMode <= um;
		aluOverflow <= ov;
		pendingInt <= pi;
		refModel(w, xl, um, ov, pi, c, e);
		@(negedge clk);
		compareOutputs();
		expCtrl = c;
		expCop0 = e;
		expName = name;
		havePrev = 1'b1;
	endtask

	task automatic drain();
		@(posedge clk);
		@(negedge clk);
		compareOutputs();
		havePrev = 1'b0;
	endtask

	task automatic resetTest();
		repeat (4) @(posedge clk);
		@(negedge clk);
		checkEq(32'(ctrl), 32'd0, "reset ctrl");
		checkEq(32'(cop0), 32'd0, "reset cop0");
		@(posedge clk);
		rstN <= 1'b1;
	endtask

	task automatic keptTest();
		for (int i = 0; i < 20; i++)
			step(mkWord(KeptOpc[i], 5'd4, 5'd5, 6'h21), 1'b0, 1'b0, 1'b0, '0,
				$sformatf("opcode %02h", KeptOpc[i]));
		for (int i = 0; i < 26; i++)
			step(mkWord(OpcRfmt, 5'd4, 5'd5, KeptFun[i]), 1'b0, 1'b0, 1'b0, '0,
				$sformatf("funct %02h", KeptFun[i]));
		step(mkWord(OpcBgeLtz, 5'd4, RtBgez, 6'h10), 1'b0, 1'b0, 1'b0, '0, "bgez");
	endtask

	task automatic reservedTest();
		for (int xl = 0; xl < 2; xl++)
			for (int i = 0; i < 10; i++)
				step(BadWords[i], xl[0], 1'b0, 1'b0, '0,
					$sformatf("reserved %08h excLevel %0d", BadWords[i], xl));
	endtask

	task automatic overflowTest();
		step(mkWord(OpcRfmt, 5'd1, 5'd2, FunAdd), 1'b0, 1'b0, 1'b1, '0, "add overflow");
		step(mkWord(OpcRfmt, 5'd1, 5'd2, FunSub), 1'b0, 1'b0, 1'b1, '0, "sub overflow");
		step(mkWord(OpcAddi, 5'd1, 5'd2, 6'h3f), 1'b0, 1'b0, 1'b1, '0, "addi overflow");
		step(mkWord(OpcRfmt, 5'd1, 5'd2, FunAddu), 1'b0, 1'b0, 1'b1, '0, "addu no trap");
		step(mkWord(OpcRfmt, 5'd0, 5'd0, FunSyscall), 1'b0, 1'b0, 1'b0, '0, "syscall");
	endtask

	task automatic interruptTest();
		logic [31:0] r;
		logic [NumInts-1:0] pi;
		int idx;
		for (int i = 0; i < 32; i++)
		begin
			r = randBits(5);
			idx = int'(r[4:0]) % 20;
			r = lfsrStep() ? randBits(NumInts) : 32'd0; // half the time no irq at all
			pi = r[NumInts-1:0];
			step(mkWord(KeptOpc[idx], 5'd3, 5'd7, 6'h00), i[0], 1'b0, 1'b0, pi,
				$sformatf("irq %02h excLevel %0d opcode %02h", pi, i[0], KeptOpc[idx]));
		end
	endtask

	task automatic privTest();
		for (int um = 0; um < 2; um++)
		begin
			step(mkWord(OpcCop0, FmtMt, 5'd5, 6'h00), 1'b0, um[0], 1'b0, '0,
				$sformatf("mtc0 userMode %0d", um));
			step(mkWord(OpcCop0, FmtEret, 5'd0, FunEret), 1'b0, um[0], 1'b0, '0,
				$sformatf("eret userMode %0d", um));
			step(mkWord(OpcCop0, FmtMf, 5'd5, 6'h00), 1'b0, um[0], 1'b0, '0,
				$sformatf("mfc0 userMode %0d", um));
		end
	endtask

	initial
	begin
		rstN = 1'b0;
		instr = mkWord(OpcLw, 5'd1, 5'd2, 6'h00); // would be visible if reset failed
		excLevel = 1'b0;
		userMode = 1'b0;
		aluOverflow = 1'b0;
		pendingInt = 8'h01;
		resetTest();
		keptTest();
		reservedTest();
		overflowTest();
		interruptTest();
		privTest();
		drain();
		$display("Done: no errors");
		$finish;
	end

	initial
	begin
		#((NumTests * CyclesPerTest + Margin) * ClkPeriod);
		$display("timeout: the tests did not finish within the time limit");
		$display("Done: errors found");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== verif/tbClock.sv ====
`timescale 1ns/1ps

module tbClock #(
	parameter int HalfPeriod = 4
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #(HalfPeriod) clk = ~clk;
	end

endmodule

// ==== rtl/ctrlUnit.sv ====
`timescale 1ns/1ps

module ctrlUnit import ctrlPkg::*; #(
	parameter int NumInts = 8
) (
	input  logic               iCLK,
	input  logic               rstN,
	input  instrWord_u         instr,
	input  logic               excLevel,
	input  logic               userMode,
	input  logic               aluOverflow,
	input  logic [NumInts-1:0] pendingInt,
	output ctrlWord_t          ctrl,
	output cop0Ctrl_t          cop0
);

	ctrlWord_t ctrlNext;
	cop0Ctrl_t cop0Next;
	excClass_e excClass;
	cop0Req_t  req;

	mainDecoder i_mainDecoder (
		.instr    (instr),
		.ctrl     (ctrlNext),
		.excClass (excClass),
		.req      (req)
	);

	excUnit #(
		.NumInts (NumInts)
	) i_excUnit (
		.excClass    (excClass),
		.req         (req),
		.excLevel    (excLevel),
		.userMode    (userMode),
		.aluOverflow (aluOverflow),
		.pendingInt  (pendingInt),
		.cop0        (cop0Next)
	);

	// output register with one cycle of latency
	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			ctrl <= '0;
			cop0 <= '0;
		end
		else
		begin
			ctrl <= ctrlNext;
			cop0 <= cop0Next;
		end
	end

	aMemExclusive: assert property (@(posedge iCLK) disable iff (!rstN)
		!(ctrl.memRead && ctrl.memWrite));
	aCop0Exclusive: assert property (@(posedge iCLK) disable iff (!rstN)
		!(cop0.regWrite && cop0.eret));
	aEretJumps: assert property (@(posedge iCLK) disable iff (!rstN)
		cop0.eret |-> ctrl.pcSrc == PcExc);

endmodule

// ==== rtl/excUnit.sv ====
`timescale 1ns/1ps

module excUnit import ctrlPkg::*; #(
	parameter int NumInts = 8
) (
	input  excClass_e          excClass,
	input  cop0Req_t           req,
	input  logic               excLevel,
	input  logic               userMode,
	input  logic               aluOverflow,
	input  logic [NumInts-1:0] pendingInt,
	output cop0Ctrl_t          cop0
);

	logic intPending;
	logic kernel;

	assign intPending = |pendingInt;
	assign kernel = ~userMode;

	always_comb
	begin
		cop0.regWrite = 1'b0;
		cop0.eret = 1'b0;
		cop0.excOccurred = 1'b0;
		cop0.branchDelay = req.branchDelay;
		cop0.excCode = ExcInt;

		case (excClass)
			ClsNone:
				cop0.excOccurred = intPending & ~excLevel;
			ClsAluOvf:
			begin
				cop0.excOccurred = (aluOverflow | intPending) & ~excLevel;
				cop0.excCode = aluOverflow ? ExcOv : ExcInt; // overflow wins over irq
			end
			ClsSyscall:
			begin
				cop0.excOccurred = ~excLevel;
				cop0.excCode = ExcSys;
			end
			ClsReserved:
			begin
				cop0.excOccurred = ~excLevel;
				cop0.excCode = ExcRi;
			end
			ClsPriv:
			begin
				// user mode traps here even with excLevel set
				cop0.excOccurred = userMode;
				cop0.excCode = ExcRi;
				cop0.regWrite = req.wantWrite & kernel;
				cop0.eret = req.wantEret & kernel;
			end
			default: ;
		endcase
	end

endmodule

// ==== rtl/mainDecoder.sv ====
`timescale 1ns/1ps

module mainDecoder import ctrlPkg::*; (
	input  instrWord_u instr,
	output ctrlWord_t  ctrl,
	output excClass_e  excClass,
	output cop0Req_t   req
);

	always_comb
	begin
		// all inactive unless a case below sets it
		ctrl = '0;
		excClass = ClsNone;
		req = '0;

		case (instr.r.opcode)
			OpcSw, OpcSh, OpcSb:
			begin
				ctrl.aluSrc = SrcSignImm;
				ctrl.memWrite = 1'b1;
			end

			OpcLb, OpcLh, OpcLw, OpcLbu, OpcLhu:
			begin
				ctrl.aluSrc = SrcSignImm;
				ctrl.memToReg = WbMem;
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
			end

			OpcBeq, OpcBne:
			begin
				ctrl.pcSrc = (instr.r.opcode == OpcBeq) ? PcBeq : PcBne;
				ctrl.aluOp = AluSub; // compare by subtraction
				req.branchDelay = 1'b1;
			end

			OpcRfmt:
			begin
				case (instr.r.funct)
					FunJr:
					begin
						ctrl.pcSrc = PcJr;
						req.branchDelay = 1'b1;
					end
					FunSyscall:
					begin
						ctrl.pcSrc = PcExc;
						excClass = ClsSyscall;
					end
					FunAdd, FunSub, FunSll, FunSrl, FunSra, FunSllv, FunSrlv, FunSrav,
					FunMfhi, FunMthi, FunMflo, FunMtlo, FunMult, FunMultu, FunDiv, FunDivu,
					FunAddu, FunSubu, FunAnd, FunOr, FunXor, FunNor, FunSlt, FunSltu:
					begin
						ctrl.regDst = RdRd;
						ctrl.regWrite = 1'b1;
						ctrl.aluOp = AluFunct;
						if (instr.r.funct == FunAdd || instr.r.funct == FunSub)
							excClass = ClsAluOvf; // signed ops trap
					end
					default: excClass = ClsReserved;
				endcase
			end

			OpcJ:
			begin
				ctrl.regDst = RdRd;
				ctrl.pcSrc = PcJump;
				req.branchDelay = 1'b1;
			end

			OpcJal:
			begin
				ctrl.regDst = RdRa;
				ctrl.memToReg = WbPc4;
				ctrl.regWrite = 1'b1;
				ctrl.pcSrc = PcJump;
				req.branchDelay = 1'b1;
			end

			OpcAddi, OpcAddiu, OpcSlti, OpcSltiu:
			begin
				ctrl.aluSrc = SrcSignImm;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = AluImm;
				if (instr.r.opcode == OpcAddi)
					excClass = ClsAluOvf;
			end

			OpcAndi, OpcOri, OpcXori:
			begin
				ctrl.aluSrc = SrcZeroImm; // logical immediates zero extend
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = AluImm;
			end

			OpcLui:
			begin
				ctrl.memToReg = WbLui;
				ctrl.regWrite = 1'b1;
			end

			OpcBgeLtz:
			begin
				if (instr.r.rt == RtBgez)
				begin
					ctrl.aluSrc = SrcZero; // rs compared against zero
					ctrl.aluOp = AluImm;
					ctrl.pcSrc = PcBeq;
					req.branchDelay = 1'b1;
				end
				else
					excClass = ClsReserved;
			end

			OpcCop0:
			begin
				case (instr.c.fmt)
					FmtMf:
					begin
						ctrl.memToReg = WbCop0;
						ctrl.regWrite = 1'b1;
						excClass = ClsPriv;
					end
					FmtMt:
					begin
						excClass = ClsPriv;
						req.wantWrite = 1'b1;
					end
					FmtEret:
					begin
						if (instr.c.funct == FunEret)
						begin
							ctrl.pcSrc = PcExc;
							excClass = ClsPriv;
							req.wantEret = 1'b1;
						end
						else
							excClass = ClsReserved;
					end
					default: excClass = ClsReserved;
				endcase
			end

			// COP1, LWC1 and SWC1 land here too
			default: excClass = ClsReserved;
		endcase
	end

endmodule

// ==== rtl/ctrlPkg.sv ====
package ctrlPkg;

	// opcodes
	localparam logic [5:0] OpcRfmt   = 6'h00;
	localparam logic [5:0] OpcBgeLtz = 6'h01;
	localparam logic [5:0] OpcJ      = 6'h02;
	localparam logic [5:0] OpcJal    = 6'h03;
	localparam logic [5:0] OpcBeq    = 6'h04;
	localparam logic [5:0] OpcBne    = 6'h05;
	localparam logic [5:0] OpcAddi   = 6'h08;
	localparam logic [5:0] OpcAddiu  = 6'h09;
	localparam logic [5:0] OpcSlti   = 6'h0a;
	localparam logic [5:0] OpcSltiu  = 6'h0b;
	localparam logic [5:0] OpcAndi   = 6'h0c;
	localparam logic [5:0] OpcOri    = 6'h0d;
	localparam logic [5:0] OpcXori   = 6'h0e;
	localparam logic [5:0] OpcLui    = 6'h0f;
	localparam logic [5:0] OpcCop0   = 6'h10;
	localparam logic [5:0] OpcLb     = 6'h20;
	localparam logic [5:0] OpcLh     = 6'h21;
	localparam logic [5:0] OpcLw     = 6'h23;
	localparam logic [5:0] OpcLbu    = 6'h24;
	localparam logic [5:0] OpcLhu    = 6'h25;
	localparam logic [5:0] OpcSb     = 6'h28;
	localparam logic [5:0] OpcSh     = 6'h29;
	localparam logic [5:0] OpcSw     = 6'h2b;

	// R-format funct field
	localparam logic [5:0] FunSll     = 6'h00;
	localparam logic [5:0] FunSrl     = 6'h02;
	localparam logic [5:0] FunSra     = 6'h03;
	localparam logic [5:0] FunSllv    = 6'h04;
	localparam logic [5:0] FunSrlv    = 6'h06;
	localparam logic [5:0] FunSrav    = 6'h07;
	localparam logic [5:0] FunJr      = 6'h08;
	localparam logic [5:0] FunSyscall = 6'h0c;
	localparam logic [5:0] FunMfhi    = 6'h10;
	localparam logic [5:0] FunMthi    = 6'h11;
	localparam logic [5:0] FunMflo    = 6'h12;
	localparam logic [5:0] FunMtlo    = 6'h13;
	localparam logic [5:0] FunMult    = 6'h18;
	localparam logic [5:0] FunMultu   = 6'h19;
	localparam logic [5:0] FunDiv     = 6'h1a;
	localparam logic [5:0] FunDivu    = 6'h1b;
	localparam logic [5:0] FunAdd     = 6'h20;
	localparam logic [5:0] FunAddu    = 6'h21;
	localparam logic [5:0] FunSub     = 6'h22;
	localparam logic [5:0] FunSubu    = 6'h23;
	localparam logic [5:0] FunAnd     = 6'h24;
	localparam logic [5:0] FunOr      = 6'h25;
	localparam logic [5:0] FunXor     = 6'h26;
	localparam logic [5:0] FunNor     = 6'h27;
	localparam logic [5:0] FunSlt     = 6'h2a;
	localparam logic [5:0] FunSltu    = 6'h2b;
	localparam logic [5:0] FunEret    = 6'h18; // only under COP0 with fmt 10000

	localparam logic [4:0] RtBgez  = 5'h01;
	localparam logic [4:0] FmtMf   = 5'h00;
	localparam logic [4:0] FmtMt   = 5'h04;
	localparam logic [4:0] FmtEret = 5'b10000;

	// cause register codes
	localparam logic [4:0] ExcInt = 5'd0;
	localparam logic [4:0] ExcSys = 5'd8;
	localparam logic [4:0] ExcRi  = 5'd10;
	localparam logic [4:0] ExcOv  = 5'd12;

	typedef enum logic [1:0] {RdRt = 2'd0, RdRd = 2'd1, RdRa = 2'd2} regDst_e;
	typedef enum logic [1:0] {SrcReg = 2'd0, SrcSignImm = 2'd1, SrcZeroImm = 2'd2,
		SrcZero = 2'd3} aluSrc_e;
	typedef enum logic [1:0] {AluAdd = 2'd0, AluSub = 2'd1, AluFunct = 2'd2,
		AluImm = 2'd3} aluOp_e;
	typedef enum logic [2:0] {WbAlu = 3'd0, WbPc4 = 3'd2, WbLui = 3'd3, WbCop0 = 3'd5,
		WbMem = 3'd6} memToReg_e;
	typedef enum logic [2:0] {PcNext = 3'd0, PcBeq = 3'd1, PcJump = 3'd2, PcJr = 3'd3,
		PcExc = 3'd4, PcBne = 3'd5} pcSrc_e;
	typedef enum logic [2:0] {ClsNone, ClsAluOvf, ClsSyscall, ClsReserved, ClsPriv} excClass_e;

	typedef struct packed {
		regDst_e   regDst;
		aluSrc_e   aluSrc;
		aluOp_e    aluOp;
		memToReg_e memToReg;
		pcSrc_e    pcSrc;
		logic      regWrite;
		logic      memRead;
		logic      memWrite;
	} ctrlWord_t;

	// what the decoder asks of COP0 before privilege gating
	typedef struct packed {
		logic wantWrite;
		logic wantEret;
		logic branchDelay;
	} cop0Req_t;

	typedef struct packed {
		logic       regWrite;
		logic       eret;
		logic       excOccurred;
		logic       branchDelay;
		logic [4:0] excCode;
	} cop0Ctrl_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rView_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] fmt; // rs slot on coprocessor ops
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} cView_t;

	typedef union packed {
		rView_t r;
		cView_t c;
	} instrWord_u;

endpackage
